//--- sram_subsystem.f
+incdir+.
sram_pkg.sv
bus_pkg.sv
sram_driver.sv
wb_bank_router.sv
bank_response_mux.sv
sram_subsystem.sv
sram_model.sv
tb_sram_subsystem.sv

//--- Bender.yml
package:
  name: sram_subsystem

sources:
  - include_dirs:
      - .
    files:
      - sram_pkg.sv
      - bus_pkg.sv
      - sram_driver.sv
      - wb_bank_router.sv
      - bank_response_mux.sv
      - sram_subsystem.sv
  - target: test
    include_dirs:
      - .
    files:
      - sram_model.sv
      - tb_sram_subsystem.sv

//--- tb_sram_subsystem.sv
`include "sram_macros.svh"

module tb_sram_subsystem
    import sram_pkg::*;
    import bus_pkg::*;
();

    localparam int ACK_TIMEOUT      = 20;
    localparam int RANDOM_TRANSFERS = 80;

    logic clk;
    logic rst;

    wb_req_t                      wb_req;
    wb_rsp_t                      wb_rsp;
    sram_pins_t [`SRAM_BANKS-1:0] sram_pins;
    wire sram_data_t [`SRAM_BANKS-1:0] sram_dq;

    logic [15:0] lfsr_state;
    sram_data_t  scoreboard [wb_addr_t];
    sram_data_t  exp_rdata;
    logic        req_issued;
    logic        tb_busy;
    logic        start_seen;
    logic        chips_idle;
    int          issued_count;
    int          ack_count;

    sram_subsystem uut (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .sram_pins (sram_pins),
        .sram_dq   (sram_dq)
    );

    for (genvar i = 0; i < `SRAM_BANKS; i++) begin : g_chip
        sram_model u_chip (
            .pins (sram_pins[i]),
            .dq   (sram_dq[i])
        );
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit handed out
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic sram_data_t expected_word(input wb_addr_t adr);
        if (scoreboard.exists(adr)) begin
            return scoreboard[adr];
        end
        return '1;
    endfunction

    // Master side view of the one access in flight
    assign start_seen = wb_req.cyc && wb_req.stb && !tb_busy;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            tb_busy   <= 1'b0;
            ack_count <= 0;
        end else begin
            if (start_seen) begin
                tb_busy <= 1'b1;
            end else if (wb_rsp.ack) begin
                tb_busy <= 1'b0;
            end
            if (wb_rsp.ack) begin
                ack_count <= ack_count + 1;
            end
        end
    end

    always_comb begin
        chips_idle = 1'b1;
        for (int b = 0; b < `SRAM_BANKS; b++) begin
            if (!sram_pins[b].cs_n || !sram_pins[b].we_n || !sram_pins[b].oe_n) begin
                chips_idle = 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !req_issued |-> !wb_rsp.ack && chips_idle)
        else stop_on_error($sformatf("FAIL %0t: bus or chips active before any request", $time));

    assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack && !wb_req.we |-> wb_rsp.dat == exp_rdata)
        else stop_on_error($sformatf("FAIL %0t: read data %h, expected %h",
            $time, wb_rsp.dat, exp_rdata));

    assert property (@(posedge clk) disable iff (rst)
        start_seen && wb_req.we |-> ##1 (!wb_rsp.ack)[*2] ##1 wb_rsp.ack ##1 !wb_rsp.ack)
        else stop_on_error($sformatf("FAIL %0t: write ack not a single pulse at T0+3", $time));

    assert property (@(posedge clk) disable iff (rst)
        start_seen && !wb_req.we |-> ##1 (!wb_rsp.ack)[*3] ##1 wb_rsp.ack ##1 !wb_rsp.ack)
        else stop_on_error($sformatf("FAIL %0t: read ack not a single pulse at T0+4", $time));

    assert property (@(posedge clk) disable iff (rst) wb_rsp.ack |-> tb_busy)
        else stop_on_error($sformatf("FAIL %0t: ack without an outstanding transfer", $time));

    for (genvar b = 0; b < `SRAM_BANKS; b++) begin : g_pin_chk
        // Adr is held by the master until after the ack edge
        assert property (@(posedge clk) disable iff (rst)
            !sram_pins[b].cs_n |-> tb_busy && wb_req.adr[`SRAM_ADDR_W +: `SRAM_BANK_W] == b)
            else stop_on_error($sformatf("FAIL %0t: bank %0d selected outside its access",
                $time, b));

        // Chip address is the low part of the bus address
        assert property (@(posedge clk) disable iff (rst)
            !sram_pins[b].cs_n |-> sram_pins[b].addr == wb_req.adr[`SRAM_ADDR_W-1:0])
            else stop_on_error($sformatf("FAIL %0t: bank %0d address %h, expected %h",
                $time, b, sram_pins[b].addr, wb_req.adr[`SRAM_ADDR_W-1:0]));

        // Write strobe only for a write with the bus data on the chip
        assert property (@(posedge clk) disable iff (rst)
            !sram_pins[b].we_n |-> wb_req.we && sram_dq[b] == wb_req.dat)
            else stop_on_error($sformatf("FAIL %0t: bank %0d write strobe with data %h",
                $time, b, sram_dq[b]));

        assert property (@(posedge clk) disable iff (rst)
            !sram_pins[b].ub_n && !sram_pins[b].lb_n)
            else stop_on_error($sformatf("FAIL %0t: byte enable off on bank %0d", $time, b));
    end

    // Called on a falling edge and returns on the falling edge after ack was sampled
    task automatic run_transfer(input logic we, input wb_addr_t adr, input sram_data_t dat);
        int waited;
        waited     = 0;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.we  = we;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        req_issued = 1'b1;
        issued_count++;
        if (we) begin
            scoreboard[adr] = dat;
        end else begin
            exp_rdata = expected_word(adr);
        end
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                stop_on_error($sformatf("No acknowledge arrived within %0d cycles for address %h",
                    ACK_TIMEOUT, adr));
            end
        end while (!wb_rsp.ack);
        @(negedge clk);
    endtask

    task automatic idle_bus(input int cycles);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    initial begin
        logic [31:0] bits;
        logic        we;
        bank_sel_t   bank;
        logic [2:0]  low;
        sram_data_t  dat;

        rst          = 1'b1;
        wb_req       = '0;
        lfsr_state   = 16'd51;
        req_issued   = 1'b0;
        issued_count = 0;
        exp_rdata    = '1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);

        // Never written word
        run_transfer(1'b0, {2'd1, 21'h000010}, '0);

        // Same chip address in every bank must stay apart
        for (int b = 0; b < `SRAM_BANKS; b++) begin
            run_transfer(1'b1, {bank_sel_t'(b), 21'h0000A5}, 16'h5A00 | b);
        end
        for (int b = 0; b < `SRAM_BANKS; b++) begin
            run_transfer(1'b0, {bank_sel_t'(b), 21'h0000A5}, '0);
        end
        idle_bus(2);

        for (int n = 0; n < RANDOM_TRANSFERS; n++) begin
            take_bits(1, bits);
            we = bits[0];
            take_bits(2, bits);
            bank = bits[1:0];
            take_bits(3, bits);
            low = bits[2:0];
            take_bits(16, bits);
            dat = bits[15:0];
            run_transfer(we, {bank, 18'h2B4C1, low}, dat);
            // A zero gap keeps stb high into the next transfer
            take_bits(2, bits);
            if (bits[1:0] != 2'd0) begin
                idle_bus(bits[1:0]);
            end
        end
        idle_bus(4);

        if (ack_count == issued_count) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_on_error($sformatf("FAIL %0t: %0d transfers issued, %0d acknowledged",
                $time, issued_count, ack_count));
        end
    end

endmodule

//--- sram_model.sv
module sram_model
    import sram_pkg::*;
(
    input  sram_pins_t      pins,
    inout  wire sram_data_t dq
);

    sram_data_t mem [sram_addr_t];

    // Write in progress, committed when we_n or cs_n rises
    logic       pend;
    sram_addr_t pend_addr;
    sram_data_t pend_data;

    sram_data_t rd_word;
    int         commit_count;

    initial begin
        pend         = 1'b0;
        commit_count = 0;
    end

    // Outputs on only for a read cycle
    assign dq = (!pins.cs_n && !pins.oe_n && pins.we_n) ? rd_word : 'z;

    // Never written words read back as all ones
    always @(pins or commit_count) begin
        if (!$isunknown(pins.addr) && mem.exists(pins.addr)) begin
            rd_word = mem[pins.addr];
        end else begin
            rd_word = '1;
        end
    end

    // Track address and data while the write strobe is low
    always @(pins or dq) begin
        if (!pins.cs_n && !pins.we_n) begin
            pend      = 1'b1;
            pend_addr = pins.addr;
            pend_data = dq;
        end
    end

    always @(posedge pins.we_n or posedge pins.cs_n) begin
        if (pend) begin
            mem[pend_addr] = pend_data;
            pend           = 1'b0;
            commit_count++;
        end
    end

endmodule

//--- sram_subsystem.sv
`include "sram_macros.svh"

module sram_subsystem
    import sram_pkg::*;
    import bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,

    input  wb_req_t                      wb_req,
    output wb_rsp_t                      wb_rsp,

    output sram_pins_t [`SRAM_BANKS-1:0] sram_pins,
    inout  wire sram_data_t [`SRAM_BANKS-1:0] sram_dq
);

    // Router to drivers
    logic [`SRAM_BANKS-1:0]       bank_req;
    logic                         write_enable;
    sram_addr_t                   address;
    sram_data_t                   write_data;
    bank_sel_t                    sel;

    // Drivers to mux
    logic [`SRAM_BANKS-1:0]       bank_done;
    sram_data_t [`SRAM_BANKS-1:0] bank_rdata;

    wb_bank_router u_router (
        .clk          (clk),
        .rst          (rst),
        .wb_req       (wb_req),
        .ack          (wb_rsp.ack),
        .req          (bank_req),
        .write_enable (write_enable),
        .address      (address),
        .write_data   (write_data),
        .sel          (sel)
    );

    for (genvar i = 0; i < `SRAM_BANKS; i++) begin : g_bank
        sram_driver u_driver (
            .clk          (clk),
            .rst          (rst),
            .req          (bank_req[i]),
            .write_enable (write_enable),
            .address      (address),
            .write_data   (write_data),
            .read_data    (bank_rdata[i]),
            .ready        (),
            .done         (bank_done[i]),
            .pins         (sram_pins[i]),
            .dq           (sram_dq[i])
        );
    end

    bank_response_mux u_mux (
        .done      (bank_done),
        .read_data (bank_rdata),
        .sel       (sel),
        .wb_rsp    (wb_rsp)
    );

endmodule

//--- bank_response_mux.sv
`include "sram_macros.svh"

module bank_response_mux
    import sram_pkg::*;
    import bus_pkg::*;
(
    input  logic [`SRAM_BANKS-1:0]       done,
    input  sram_data_t [`SRAM_BANKS-1:0] read_data,
    input  bank_sel_t                    sel,
    output wb_rsp_t                      wb_rsp
);

    // Only one driver can finish at a time, so an OR is enough
    assign wb_rsp.ack = |done;

    // Sel stays put through the access, so no need to decode done
    assign wb_rsp.dat = read_data[sel];

    always_comb begin
        assert final ($onehot0(done))
            else $error("several banks finished together");
        if (|done) begin
            assert final (done[sel])
                else $error("done from bank other than the selected one");
        end
    end

endmodule

//--- wb_bank_router.sv
`include "sram_macros.svh"

module wb_bank_router
    import sram_pkg::*;
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  wb_req_t                wb_req,
    input  logic                   ack,

    output logic [`SRAM_BANKS-1:0] req,
    output logic                   write_enable,
    output sram_addr_t             address,
    output sram_data_t             write_data,
    output bank_sel_t              sel
);

    logic       busy;
    logic       start;
    bank_sel_t  req_bank;
    sram_addr_t req_addr;

    // Bank in the top bits with the chip word address below
    assign req_bank = wb_req.adr[`SRAM_ADDR_W +: `SRAM_BANK_W];
    assign req_addr = wb_req.adr[`SRAM_ADDR_W-1:0];

    // One access per bus cycle and nothing new until the previous ack
    assign start = wb_req.cyc && wb_req.stb && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            req  <= '0;
        end else begin
            req <= '0;
            if (start) begin
                busy          <= 1'b1;
                req[req_bank] <= 1'b1;
            end else if (ack) begin
                busy <= 1'b0;
            end
        end
    end

    // Held until the next start so the mux can steer read data
    always_ff @(posedge clk) begin
        if (start) begin
            sel          <= req_bank;
            address      <= req_addr;
            write_data   <= wb_req.dat;
            write_enable <= wb_req.we;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(req))
        else $error("more than one bank requested");

    // After a request nothing new goes out up to and including its ack
    assert property (@(posedge clk) disable iff (rst)
        (req != '0) |=> ((req == '0) until_with ack))
        else $error("request issued while an access was outstanding");

endmodule

//--- sram_driver.sv
module sram_driver
    import sram_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       req,
    input  logic       write_enable,
    input  sram_addr_t address,
    input  sram_data_t write_data,
    output sram_data_t read_data,
    output logic       ready,
    output logic       done,

    output sram_pins_t pins,
    inout  wire sram_data_t dq
);

    drv_state_t state;
    drv_state_t next_state;

    // Request captured when leaving IDLE
    sram_addr_t addr_reg;
    sram_data_t wdata_reg;
    logic       we_reg;

    logic       dq_oe;
    logic       finish;

    // Release the bus unless a write is in its SETUP cycle
    assign dq = dq_oe ? wdata_reg : 'z;

    // Last cycle of a write SETUP or a read ACCESS
    assign finish = (state == SETUP && we_reg) || (state == ACCESS);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            we_reg <= 1'b0;
            done   <= 1'b0;
        end else begin
            state <= next_state;
            done  <= finish;
            if (state == IDLE && req) begin
                we_reg <= write_enable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            addr_reg  <= address;
            wdata_reg <= write_data;
        end
        // Sample the chip output at the end of ACCESS
        if (state == ACCESS) begin
            read_data <= dq;
        end
    end

    always_comb begin
        next_state = state;
        ready      = 1'b0;
        dq_oe      = 1'b0;

        pins.addr  = addr_reg;
        pins.cs_n  = 1'b1;
        pins.we_n  = 1'b1;
        pins.oe_n  = 1'b1;
        // Both byte lanes always on for full words
        pins.ub_n  = 1'b0;
        pins.lb_n  = 1'b0;

        unique case (state)
            IDLE: begin
                ready = 1'b1;
                if (req) begin
                    next_state = SETUP;
                end
            end

            SETUP: begin
                pins.cs_n = 1'b0;
                if (we_reg) begin
                    pins.we_n  = 1'b0;
                    dq_oe      = 1'b1;
                    next_state = IDLE;
                end else begin
                    // Outputs on now so data settles through ACCESS
                    pins.oe_n  = 1'b0;
                    next_state = ACCESS;
                end
            end

            ACCESS: begin
                pins.cs_n  = 1'b0;
                pins.oe_n  = 1'b0;
                next_state = IDLE;
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Never fight the chip while its outputs are on or just turned off
    assert property (@(posedge clk) disable iff (rst)
        dq_oe |-> pins.oe_n && $past(pins.oe_n))
        else $error("dq driven while oe_n is low or just released");

    // The router only starts an access on an idle driver
    assert property (@(posedge clk) disable iff (rst) req |-> ready)
        else $error("req arrived while driver busy");

endmodule

//--- bus_pkg.sv
`include "sram_macros.svh"

package bus_pkg;

    import sram_pkg::*;

    // Wishbone word address, bank index in the top bits
    typedef logic [`WB_ADDR_W-1:0]   wb_addr_t;
    typedef logic [`SRAM_BANK_W-1:0] bank_sel_t;

    // Master to slave, classic cycle without byte selects
    typedef struct packed {
        wb_addr_t   adr;
        sram_data_t dat;
        logic       we;
        logic       cyc;
        logic       stb;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        sram_data_t dat;
        logic       ack;
    } wb_rsp_t;

endpackage

//--- sram_pkg.sv
`include "sram_macros.svh"

package sram_pkg;

    // Chip word address and data word
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
    typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

    // Chip control and address pins, all active low except addr
    typedef struct packed {
        sram_addr_t addr;
        logic       cs_n;
        logic       we_n;
        logic       oe_n;
        logic       ub_n;
        logic       lb_n;
    } sram_pins_t;

    // Driver sequencer states
    // A write uses SETUP only, a read goes SETUP then ACCESS
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } drv_state_t;

endpackage

//--- sram_macros.svh
`ifndef SRAM_MACROS_SVH
`define SRAM_MACROS_SVH

// Word address width of one SRAM chip
`define SRAM_ADDR_W 21

// Data bus width of one chip, also the Wishbone data width
`define SRAM_DATA_W 16

// Number of chips behind the Wishbone slave
`define SRAM_BANKS 4

// Bits needed to pick one bank, taken from the top of the bus address
`define SRAM_BANK_W 2

// Full Wishbone word address: bank bits on top of the chip address
`define WB_ADDR_W (`SRAM_BANK_W + `SRAM_ADDR_W)

`endif
